//--- hdl/ctrk_pkg.sv
// Color tracker shared definitions
// Enums, thresholds, frame geometry and APB register map
`default_nettype none

package ctrk_pkg;

    // ==============================
    // Types
    // ==============================
    typedef enum logic [1:0] {
        COLOR_RED   = 2'd0,
        COLOR_GREEN = 2'd1,
        COLOR_BLUE  = 2'd2            // Code 3 falls back to red
    } color_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ARMED = 2'd1,
        ST_TRACK = 2'd2,
        ST_DONE  = 2'd3
    } state_e;

    // ==============================
    // Geometry
    // ==============================
    localparam int PIX_W   = 8;       // Per H, S, V component
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 8;
    localparam int COL_W   = 4;
    localparam int ROW_W   = 3;
    localparam int CNT_W   = 8;       // Up to 128 hits

    localparam logic [COL_W-1:0] COL_LAST = COL_W'(FRAME_W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(FRAME_H - 1);

    // ==============================
    // Color windows, all inclusive
    // ==============================
    localparam logic [PIX_W-1:0] RED_H_LO_MAX = 8'd15;   // Red wraps through zero
    localparam logic [PIX_W-1:0] RED_H_HI_MIN = 8'd240;
    localparam logic [PIX_W-1:0] GREEN_H_MIN  = 8'd60;
    localparam logic [PIX_W-1:0] GREEN_H_MAX  = 8'd110;
    localparam logic [PIX_W-1:0] BLUE_H_MIN   = 8'd150;
    localparam logic [PIX_W-1:0] BLUE_H_MAX   = 8'd190;
    localparam logic [PIX_W-1:0] RED_S_MIN    = 8'd120;
    localparam logic [PIX_W-1:0] GREEN_S_MIN  = 8'd80;
    localparam logic [PIX_W-1:0] BLUE_S_MIN   = 8'd80;
    localparam logic [PIX_W-1:0] V_MIN        = 8'd70;   // Shared by all colors

    // Register map
    localparam logic [7:0] REG_CTRL   = 8'h00;   // start, color, irq_en
    localparam logic [7:0] REG_STATUS = 8'h04;   // busy, done (W1C)
    localparam logic [7:0] REG_COUNT  = 8'h08;
    localparam logic [7:0] REG_BBOX_X = 8'h0C;
    localparam logic [7:0] REG_BBOX_Y = 8'h10;

endpackage

`default_nettype wire

//--- hdl/hsv_classifier.sv
// HSV color classifier
// Two-stage pipeline testing each pixel against the selected color window
`timescale 1ns/100ps
`default_nettype none

module hsv_classifier (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       pix_valid,
    input  wire logic                       pix_sof,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_h,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_s,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_v,
    input  wire ctrk_pkg::color_e           color,
    output logic                            cls_valid,
    output logic                            cls_sof,
    output logic                            cls_hit
);

    logic h_ok, s_ok, v_ok;             // Stage one compare results
    logic valid_s1, sof_s1;
    logic h_s1, s_s1, v_s1;

    // Window select with red as the fallback
    always_comb begin
        case (color)
            ctrk_pkg::COLOR_GREEN: begin
                h_ok = (pix_h >= ctrk_pkg::GREEN_H_MIN) && (pix_h <= ctrk_pkg::GREEN_H_MAX);
                s_ok = pix_s >= ctrk_pkg::GREEN_S_MIN;
            end
            ctrk_pkg::COLOR_BLUE: begin
                h_ok = (pix_h >= ctrk_pkg::BLUE_H_MIN) && (pix_h <= ctrk_pkg::BLUE_H_MAX);
                s_ok = pix_s >= ctrk_pkg::BLUE_S_MIN;
            end
            default: begin
                // Two ranges around zero
                h_ok = (pix_h <= ctrk_pkg::RED_H_LO_MAX) || (pix_h >= ctrk_pkg::RED_H_HI_MIN);
                s_ok = pix_s >= ctrk_pkg::RED_S_MIN;
            end
        endcase
        v_ok = pix_v >= ctrk_pkg::V_MIN;
    end

    // ==============================
    // Stage one
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            sof_s1   <= 1'b0;
        end else begin
            valid_s1 <= pix_valid;
            sof_s1   <= pix_valid && pix_sof;   // sof only counts with a pixel
        end
    end

    always_ff @(posedge clk) begin
        h_s1 <= h_ok;
        s_s1 <= s_ok;
        v_s1 <= v_ok;
    end

    // ==============================
    // Stage two
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cls_valid <= 1'b0;
            cls_sof   <= 1'b0;
            cls_hit   <= 1'b0;
        end else begin
            cls_valid <= valid_s1;
            cls_sof   <= sof_s1;
            cls_hit   <= valid_s1 && h_s1 && s_s1 && v_s1;  // Low in gaps
        end
    end

    // A hit traces back to a pixel above the value floor two edges earlier
    a_hit_value_floor: assert property (@(posedge clk) disable iff (!rst_n)
        cls_hit |-> ($past(pix_v, 2) >= ctrk_pkg::V_MIN));

endmodule

`default_nettype wire

//--- hdl/pixel_position_counter.sv
// Raster position counter
// Column and row of each classified pixel, restarted by start-of-frame
`timescale 1ns/100ps
`default_nettype none

module pixel_position_counter (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cls_valid,
    input  wire logic                       cls_sof,
    output logic [ctrk_pkg::COL_W-1:0]      col,
    output logic [ctrk_pkg::ROW_W-1:0]      row,
    output logic                            frame_last
);

    logic [ctrk_pkg::COL_W-1:0] col_q;  // Position of the next pixel
    logic [ctrk_pkg::ROW_W-1:0] row_q;
    logic                       col_end;

    // sof pixel always sits at 0,0
    assign col     = cls_sof ? '0 : col_q;
    assign row     = cls_sof ? '0 : row_q;
    assign col_end = (col == ctrk_pkg::COL_LAST);

    assign frame_last = cls_valid && col_end && (row == ctrk_pkg::ROW_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (cls_valid) begin
            if (col_end) begin
                col_q <= '0;
                row_q <= (row == ctrk_pkg::ROW_LAST) ? '0 : row + 1'b1;  // Wrap to row 0
            end else begin
                col_q <= col + 1'b1;
                row_q <= row;
            end
        end
    end

    // Next frame starts at the origin after the last pixel
    a_wrap_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        frame_last |=> (col_q == '0) && (row_q == '0));

endmodule

`default_nettype wire

//--- hdl/target_accumulator.sv
// Target statistics
// Hit count and bounding box of the hits in one frame
`timescale 1ns/100ps
`default_nettype none

module target_accumulator (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       acc_clear,
    input  wire logic                       acc_en,
    input  wire logic                       cls_hit,
    input  wire logic [ctrk_pkg::COL_W-1:0] col,
    input  wire logic [ctrk_pkg::ROW_W-1:0] row,
    output logic [ctrk_pkg::CNT_W-1:0]      hit_count,
    output logic [ctrk_pkg::COL_W-1:0]      min_col,
    output logic [ctrk_pkg::COL_W-1:0]      max_col,
    output logic [ctrk_pkg::ROW_W-1:0]      min_row,
    output logic [ctrk_pkg::ROW_W-1:0]      max_row
);

    logic any_hit;                      // Box holds at least one hit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            any_hit   <= 1'b0;
            hit_count <= '0;
            min_col   <= '0;
            max_col   <= '0;
            min_row   <= '0;
            max_row   <= '0;
        end else if (acc_en) begin
            if (acc_clear) begin
                // First pixel of the frame seeds the statistics
                any_hit   <= cls_hit;
                hit_count <= cls_hit ? ctrk_pkg::CNT_W'(1) : '0;
                min_col   <= cls_hit ? col : '0;  // Empty box is all zeros
                max_col   <= cls_hit ? col : '0;
                min_row   <= cls_hit ? row : '0;
                max_row   <= cls_hit ? row : '0;
            end else if (cls_hit) begin
                any_hit   <= 1'b1;
                hit_count <= hit_count + 1'b1;
                if (!any_hit) begin
                    min_col <= col;
                    max_col <= col;
                    min_row <= row;
                    max_row <= row;
                end else begin
                    // Widen the box
                    if (col < min_col) min_col <= col;
                    if (col > max_col) max_col <= col;
                    if (row < min_row) min_row <= row;
                    if (row > max_row) max_row <= row;
                end
            end
        end
    end

    // Box stays ordered once there is something in it
    a_box_order: assert property (@(posedge clk) disable iff (!rst_n)
        (hit_count != '0) |-> (min_col <= max_col) && (min_row <= max_row));

endmodule

`default_nettype wire

//--- hdl/track_ctrl_fsm.sv
// Tracking control FSM
// Arms on start, tracks one frame from its sof pixel, then reports done
`timescale 1ns/100ps
`default_nettype none

module track_ctrl_fsm (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    input  wire logic cls_valid,
    input  wire logic cls_sof,
    input  wire logic frame_last,
    output logic      acc_clear,
    output logic      acc_en,
    output logic      done_set,
    output logic      busy
);

    ctrk_pkg::state_e state_q, state_d;

    // Accumulator steering
    assign acc_clear = (state_q == ctrk_pkg::ST_ARMED) && cls_valid && cls_sof;
    assign acc_en    = acc_clear || ((state_q == ctrk_pkg::ST_TRACK) && cls_valid);
    assign done_set  = (state_q == ctrk_pkg::ST_TRACK) && frame_last;
    assign busy      = (state_q == ctrk_pkg::ST_ARMED) || (state_q == ctrk_pkg::ST_TRACK);

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ctrk_pkg::ST_IDLE:  if (start) state_d = ctrk_pkg::ST_ARMED;
            ctrk_pkg::ST_ARMED: if (acc_clear) state_d = ctrk_pkg::ST_TRACK;
            ctrk_pkg::ST_TRACK: if (done_set) state_d = ctrk_pkg::ST_DONE;
            default:            state_d = ctrk_pkg::ST_IDLE;  // One cycle in done
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ctrk_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Only one done per tracked frame
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_set |=> !done_set);

endmodule

`default_nettype wire

//--- hdl/apb_track_regs.sv
// APB register block for the color tracker
// Control, status and result registers, start pulse and interrupt
// Zero wait states, unmapped addresses read as zero
`timescale 1ns/100ps
`default_nettype none

module apb_track_regs (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [7:0]                 paddr,
    input  wire logic [31:0]                pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            start,
    output ctrk_pkg::color_e                color,
    output logic                            irq,
    input  wire logic                       busy,
    input  wire logic                       done_set,
    input  wire logic [ctrk_pkg::CNT_W-1:0] hit_count,
    input  wire logic [ctrk_pkg::COL_W-1:0] min_col,
    input  wire logic [ctrk_pkg::COL_W-1:0] max_col,
    input  wire logic [ctrk_pkg::ROW_W-1:0] min_row,
    input  wire logic [ctrk_pkg::ROW_W-1:0] max_row
);

    logic irq_en;
    logic done;                         // Sticky until W1C or new start
    logic wr_en, wr_ctrl, wr_status, go;

    assign pready    = 1'b1;
    assign wr_en     = psel && penable && pwrite;  // End of access phase
    assign wr_ctrl   = wr_en && (paddr == ctrk_pkg::REG_CTRL);
    assign wr_status = wr_en && (paddr == ctrk_pkg::REG_STATUS);
    assign go        = wr_ctrl && pwdata[0] && !busy;  // Dropped while tracking

    assign irq = done && irq_en;

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            color  <= ctrk_pkg::COLOR_RED;
            irq_en <= 1'b0;
            start  <= 1'b0;
            done   <= 1'b0;
        end else begin
            start <= go;                // One cycle wide
            if (wr_ctrl) begin
                color  <= ctrk_pkg::color_e'(pwdata[2:1]);
                irq_en <= pwdata[3];
            end
            if (done_set) begin
                done <= 1'b1;
            end else if (go || (wr_status && pwdata[1])) begin
                done <= 1'b0;
            end
        end
    end

    // Read mux, start bit reads back as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            ctrk_pkg::REG_CTRL:   prdata[3:1] = {irq_en, color};
            ctrk_pkg::REG_STATUS: prdata[1:0] = {done, busy};
            ctrk_pkg::REG_COUNT:  prdata[ctrk_pkg::CNT_W-1:0] = hit_count;
            ctrk_pkg::REG_BBOX_X: prdata[11:0] = {max_col, 4'd0, min_col};
            ctrk_pkg::REG_BBOX_Y: prdata[10:0] = {max_row, 5'd0, min_row};
            default:              prdata = '0;
        endcase
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

endmodule

`default_nettype wire

//--- hdl/color_tracker_top.sv
// Color tracker top level
// Classifier, position counter, accumulator, control FSM and APB registers
`timescale 1ns/100ps
`default_nettype none

module color_tracker_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [7:0]                 paddr,
    input  wire logic [31:0]                pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    input  wire logic                       pix_valid,
    input  wire logic                       pix_sof,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_h,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_s,
    input  wire logic [ctrk_pkg::PIX_W-1:0] pix_v,
    output logic                            irq
);

    // ==============================
    // Internal nets
    // ==============================
    ctrk_pkg::color_e           color;
    logic                       start, busy, done_set;
    logic                       cls_valid, cls_sof, cls_hit;
    logic [ctrk_pkg::COL_W-1:0] col, min_col, max_col;
    logic [ctrk_pkg::ROW_W-1:0] row, min_row, max_row;
    logic                       frame_last;
    logic                       acc_clear, acc_en;
    logic [ctrk_pkg::CNT_W-1:0] hit_count;

    hsv_classifier cls_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_sof   (pix_sof),
        .pix_h     (pix_h),
        .pix_s     (pix_s),
        .pix_v     (pix_v),
        .color     (color),
        .cls_valid (cls_valid),
        .cls_sof   (cls_sof),
        .cls_hit   (cls_hit)
    );

    pixel_position_counter pos_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cls_valid  (cls_valid),
        .cls_sof    (cls_sof),
        .col        (col),
        .row        (row),
        .frame_last (frame_last)
    );

    target_accumulator acc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .cls_hit   (cls_hit),
        .col       (col),
        .row       (row),
        .hit_count (hit_count),
        .min_col   (min_col),
        .max_col   (max_col),
        .min_row   (min_row),
        .max_row   (max_row)
    );

    track_ctrl_fsm fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cls_valid  (cls_valid),
        .cls_sof    (cls_sof),
        .frame_last (frame_last),
        .acc_clear  (acc_clear),
        .acc_en     (acc_en),
        .done_set   (done_set),
        .busy       (busy)
    );

    apb_track_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .start     (start),
        .color     (color),
        .irq       (irq),
        .busy      (busy),
        .done_set  (done_set),
        .hit_count (hit_count),
        .min_col   (min_col),
        .max_col   (max_col),
        .min_row   (min_row),
        .max_row   (max_row)
    );

endmodule

`default_nettype wire

//--- bench/tb_color_tracker.sv
// Color tracker testbench
// APB tasks, frame driver, reference model, assertions and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_color_tracker;

    localparam int NPIX    = ctrk_pkg::FRAME_W * ctrk_pkg::FRAME_H;
    localparam int CLK_NS  = 100;
    localparam int WDOG_NS = (6 * 128 * 3 + 2000) * CLK_NS;  // Gapped frames plus slack

    logic        clk, rst_n;
    logic        psel, penable, pwrite, pready;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pix_valid, pix_sof, irq;
    logic [7:0]  pix_h, pix_s, pix_v;

    logic [7:0]  fh [NPIX];             // Frame under test, raster order
    logic [7:0]  fs [NPIX];
    logic [7:0]  fv [NPIX];
    logic [31:0] last_cnt;              // COUNT of the last tracked frame
    int          err_count, pass_count, fail_count;

    color_tracker_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pix_valid(pix_valid), .pix_sof(pix_sof),
        .pix_h(pix_h), .pix_s(pix_s), .pix_v(pix_v),
        .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==============================
    // Protocol assertions
    // ==============================
    a_irq_in_reset: assert property (@(posedge clk) !rst_n |-> !irq)
        else begin $display("Assertion failed: irq high during reset"); err_count++; end
    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin $display("Assertion failed: pready dropped low"); err_count++; end

    // ==============================
    // APB and check tasks
    // ==============================
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk); #10;
        psel = 1'b1; penable = 1'b0; pwrite = 1'b1; paddr = addr; pwdata = data;
        @(posedge clk); #10;
        penable = 1'b1;                 // Takes effect at the next edge
        @(posedge clk); #10;
        psel = 1'b0; penable = 1'b0; pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk); #10;
        psel = 1'b1; penable = 1'b0; pwrite = 1'b0; paddr = addr;
        @(posedge clk); #10;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;                  // Mid access phase
        @(posedge clk); #10;
        psel = 1'b0; penable = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        apb_read(addr, got);
        assert (got == exp) else begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_irq(input logic exp);
        assert (irq === exp) else begin
            $display("Error: irq = 0x%h, expected 0x%h", irq, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (err_count == mark) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, err_count - mark);
        end
    endtask

    // ==============================
    // Frame data and reference model
    // ==============================
    function automatic void set_pixel(input int idx, input logic [7:0] h, s, v);
        fh[idx] = h;
        fs[idx] = s;
        fv[idx] = v;
    endfunction

    // Zero saturation, so nothing matches
    function automatic void fill_background();
        for (int i = 0; i < NPIX; i++) begin
            set_pixel(i, 8'(i * 2), 8'd0, 8'(255 - i));
        end
    endfunction

    // Hue, S and V edges of one window
    function automatic void load_edge_frame(input logic [1:0] c);
        logic [7:0] lo, hi, smin, mid;
        case (c)
            ctrk_pkg::COLOR_GREEN: begin
                lo = ctrk_pkg::GREEN_H_MIN; hi = ctrk_pkg::GREEN_H_MAX;
                smin = ctrk_pkg::GREEN_S_MIN; mid = 8'd85;
            end
            ctrk_pkg::COLOR_BLUE: begin
                lo = ctrk_pkg::BLUE_H_MIN; hi = ctrk_pkg::BLUE_H_MAX;
                smin = ctrk_pkg::BLUE_S_MIN; mid = 8'd170;
            end
            default: begin
                lo = ctrk_pkg::RED_H_HI_MIN; hi = ctrk_pkg::RED_H_LO_MAX;  // Wrapped pair
                smin = ctrk_pkg::RED_S_MIN; mid = 8'd250;
            end
        endcase
        fill_background();
        set_pixel(3, lo, smin, ctrk_pkg::V_MIN);            // Exact minimums
        set_pixel(20, hi, 8'd255, 8'd255);
        set_pixel(37, hi + 8'd1, 8'd255, 8'd255);
        set_pixel(54, lo - 8'd1, 8'd255, 8'd255);
        set_pixel(71, lo, smin - 8'd1, 8'd255);
        set_pixel(88, hi, 8'd255, ctrk_pkg::V_MIN - 8'd1);
        set_pixel(110, mid, 8'd200, 8'd200);
    endfunction

    // Threshold rule, all bounds inclusive
    function automatic logic is_hit(input logic [1:0] c, input logic [7:0] h, s, v);
        logic h_in, s_in;
        case (c)
            ctrk_pkg::COLOR_GREEN: begin
                h_in = (h >= ctrk_pkg::GREEN_H_MIN) && (h <= ctrk_pkg::GREEN_H_MAX);
                s_in = s >= ctrk_pkg::GREEN_S_MIN;
            end
            ctrk_pkg::COLOR_BLUE: begin
                h_in = (h >= ctrk_pkg::BLUE_H_MIN) && (h <= ctrk_pkg::BLUE_H_MAX);
                s_in = s >= ctrk_pkg::BLUE_S_MIN;
            end
            default: begin
                h_in = (h <= ctrk_pkg::RED_H_LO_MAX) || (h >= ctrk_pkg::RED_H_HI_MIN);
                s_in = s >= ctrk_pkg::RED_S_MIN;
            end
        endcase
        return h_in && s_in && (v >= ctrk_pkg::V_MIN);
    endfunction

    function automatic void model_frame(input logic [1:0] c, output logic [31:0] cnt,
                                        output logic [31:0] bx, output logic [31:0] by);
        int n, col, row, cmin, cmax, rmin, rmax;
        n = 0; cmin = 0; cmax = 0; rmin = 0; rmax = 0;   // Empty box reads zero
        for (int i = 0; i < NPIX; i++) begin
            col = i % ctrk_pkg::FRAME_W;
            row = i / ctrk_pkg::FRAME_W;
            if (is_hit(c, fh[i], fs[i], fv[i])) begin
                if (n == 0 || col < cmin) cmin = col;
                if (n == 0 || col > cmax) cmax = col;
                if (n == 0 || row < rmin) rmin = row;
                if (n == 0 || row > rmax) rmax = row;
                n++;
            end
        end
        cnt = 32'(n);
        bx  = 32'((cmax << 8) | cmin);
        by  = 32'((rmax << 8) | rmin);
    endfunction

    // ==============================
    // Stream and tracking tasks
    // ==============================
    task automatic send_pixels(input int n, input logic with_sof, input logic gaps);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = gaps ? int'($urandom_range(0, 2)) : 0;
            repeat (gap) begin
                @(posedge clk); #10;
                pix_valid = 1'b0; pix_sof = 1'b0;
                pix_h = 8'($urandom);   // Junk in gaps
            end
            @(posedge clk); #10;
            pix_valid = 1'b1; pix_sof = with_sof && (i == 0);
            pix_h = fh[i]; pix_s = fs[i]; pix_v = fv[i];
        end
        @(posedge clk); #10;
        pix_valid = 1'b0; pix_sof = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int polls;
        st = '0;
        polls = 0;
        while (!st[1] && polls < 40) begin
            apb_read(ctrk_pkg::REG_STATUS, st);
            polls++;
        end
        if (!st[1]) begin
            $display("Timeout: done flag never set after the frame");
            err_count++;
        end
    endtask

    task automatic start_tracking(input logic [1:0] c, input logic irq_en);
        apb_write(ctrk_pkg::REG_CTRL, {28'd0, irq_en, c, 1'b1});
    endtask

    task automatic check_results(input logic [1:0] c);
        logic [31:0] cnt, bx, by;
        model_frame(c, cnt, bx, by);
        check_reg("COUNT", ctrk_pkg::REG_COUNT, cnt);
        check_reg("BBOX_X", ctrk_pkg::REG_BBOX_X, bx);
        check_reg("BBOX_Y", ctrk_pkg::REG_BBOX_Y, by);
        check_reg("STATUS", ctrk_pkg::REG_STATUS, 32'h2);   // Done, not busy
        last_cnt = cnt;
    endtask

    task automatic track_frame(input logic [1:0] c, input logic gaps);
        start_tracking(c, 1'b1);
        send_pixels(NPIX, 1'b1, gaps);
        wait_done();
        check_results(c);
        apb_write(ctrk_pkg::REG_STATUS, 32'h2);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int mark;
        logic [1:0] c;
        void'($urandom(32'hcdd));
        err_count = 0; pass_count = 0; fail_count = 0; last_cnt = '0;
        rst_n = 1'b0; psel = 1'b0; penable = 1'b0; pwrite = 1'b0;
        paddr = '0; pwdata = '0;
        pix_valid = 1'b0; pix_sof = 1'b0; pix_h = '0; pix_s = '0; pix_v = '0;
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;

        mark = err_count;
        check_reg("STATUS", ctrk_pkg::REG_STATUS, 32'h0);
        check_reg("COUNT", ctrk_pkg::REG_COUNT, 32'h0);
        check_reg("BBOX_X", ctrk_pkg::REG_BBOX_X, 32'h0);
        check_reg("BBOX_Y", ctrk_pkg::REG_BBOX_Y, 32'h0);
        check_irq(1'b0);
        apb_write(ctrk_pkg::REG_CTRL, 32'hA);                // Green, irq_en
        check_reg("CTRL", ctrk_pkg::REG_CTRL, 32'hA);
        apb_write(ctrk_pkg::REG_CTRL, 32'h4);                // Blue
        check_reg("CTRL", ctrk_pkg::REG_CTRL, 32'h4);
        finish_test("reset and registers", mark);

        mark = err_count;
        for (int k = 0; k < 3; k++) begin
            load_edge_frame(2'(k));
            track_frame(2'(k), 1'b0);
        end
        finish_test("per-color classification", mark);

        mark = err_count;
        fill_background();
        set_pixel(2, 8'd0, 8'd255, 8'd255);
        set_pixel(19, 8'd15, 8'd255, 8'd255);
        set_pixel(36, 8'd240, 8'd255, 8'd255);
        set_pixel(53, 8'd255, 8'd255, 8'd255);
        set_pixel(70, 8'd16, 8'd255, 8'd255);
        set_pixel(87, 8'd128, 8'd255, 8'd255);
        set_pixel(104, 8'd239, 8'd255, 8'd255);
        track_frame(ctrk_pkg::COLOR_RED, 1'b0);
        check_reg("COUNT", ctrk_pkg::REG_COUNT, 32'd4);      // Only the four wrap edges
        finish_test("red wrap-around", mark);

        mark = err_count;
        for (int i = 0; i < NPIX; i++) begin
            set_pixel(i, (i % 3 == 0) ? 8'd250 : 8'd100, 8'd200, 8'd200);
        end
        send_pixels(NPIX, 1'b1, 1'b0);                       // Tracker idle
        start_tracking(ctrk_pkg::COLOR_RED, 1'b1);
        send_pixels(20, 1'b0, 1'b0);                         // Armed, no sof yet
        check_reg("STATUS", ctrk_pkg::REG_STATUS, 32'h1);
        check_reg("COUNT", ctrk_pkg::REG_COUNT, last_cnt);
        start_tracking(ctrk_pkg::COLOR_RED, 1'b1);           // Busy, so dropped
        check_reg("STATUS", ctrk_pkg::REG_STATUS, 32'h1);
        send_pixels(NPIX, 1'b1, 1'b0);
        wait_done();
        check_results(ctrk_pkg::COLOR_RED);
        check_irq(1'b1);
        apb_write(ctrk_pkg::REG_CTRL, 32'h0);                // irq_en off
        check_irq(1'b0);
        apb_write(ctrk_pkg::REG_CTRL, 32'h8);
        check_irq(1'b1);
        apb_write(ctrk_pkg::REG_STATUS, 32'h2);              // W1C done
        check_irq(1'b0);
        check_reg("STATUS", ctrk_pkg::REG_STATUS, 32'h0);
        finish_test("frame control", mark);

        mark = err_count;
        fill_background();
        track_frame(ctrk_pkg::COLOR_GREEN, 1'b0);
        check_reg("COUNT", ctrk_pkg::REG_COUNT, 32'h0);
        finish_test("empty frame", mark);

        mark = err_count;
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < NPIX; i++) begin
                set_pixel(i, 8'($urandom), 8'($urandom), 8'($urandom));
            end
            c = 2'($urandom_range(0, 2));
            track_frame(c, 1'b1);
        end
        finish_test("random frames", mark);

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/ctrk_pkg.sv
hdl/hsv_classifier.sv
hdl/pixel_position_counter.sv
hdl/target_accumulator.sv
hdl/track_ctrl_fsm.sv
hdl/apb_track_regs.sv
hdl/color_tracker_top.sv
bench/tb_color_tracker.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_color_tracker
FILELIST  := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
